// ==== logic/apb_host_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module apb_host_port (
    input  wire logic                           I_CLK,
    input  wire logic                           I_RST_N,
    input  wire logic                           psel_i,
    input  wire logic                           penable_i,
    input  wire logic                           pwrite_i,
    input  wire logic [attn_pkg::ADDR_W-1:0]    paddr_i,
    input  wire logic [attn_pkg::WORD_W-1:0]    pwdata_i,
    input  wire logic                           done_i,
    input  wire logic                           busy_i,
    input  wire logic                           h_gnt_i,
    input  wire logic                           h_rvalid_i,
    input  wire logic [attn_pkg::WORD_W-1:0]    h_rdata_i,
    output logic                                pready_o,
    output logic [attn_pkg::WORD_W-1:0]         prdata_o,
    output logic                                start_o,
    output logic                                h_req_o,
    output logic                                h_we_o,
    output logic [attn_pkg::ADDR_W-1:0]         h_addr_o,
    output logic [attn_pkg::WORD_W-1:0]         h_wdata_o
);

    logic access;   // apb access phase
    logic is_ctrl;
    logic ctrl_acc;
    logic rd_wait;  // read granted, data due next cycle

    assign access   = psel_i & penable_i;
    assign is_ctrl  = (paddr_i == attn_pkg::CTRL_ADDR);
    assign ctrl_acc = access & is_ctrl;

    // start only when the engine is idle
    assign start_o = ctrl_acc & pwrite_i & pwdata_i[0] & ~busy_i;

    ////////////////////////////////////////
    // memory request side
    ////////////////////////////////////////
    assign h_req_o   = access & ~is_ctrl & ~rd_wait; // drop req once read granted
    assign h_we_o    = pwrite_i;
    assign h_addr_o  = paddr_i;
    assign h_wdata_o = pwdata_i;

    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            rd_wait <= 1'b0;
        end else if (h_gnt_i && !pwrite_i) begin
            rd_wait <= 1'b1;
        end else if (h_rvalid_i) begin
            rd_wait <= 1'b0;
        end
    end

    // writes finish on the grant, reads on the returning data
    assign pready_o = ctrl_acc | (h_gnt_i & pwrite_i) | (rd_wait & h_rvalid_i);

    assign prdata_o = is_ctrl ? {{(attn_pkg::WORD_W-2){1'b0}}, done_i, busy_i}
                              : h_rdata_i;

endmodule

`default_nettype wire

// ==== logic/attn_pkg.sv ====
`default_nettype none

package attn_pkg;

    ////////////////////////////////////////
    // sizes
    ////////////////////////////////////////
    localparam int unsigned ELEM_W      = 8;  // signed int8 elements
    localparam int unsigned WORD_W      = 32; // four lanes, lane 0 in bits 7..0
    localparam int unsigned TILE        = 4;
    localparam int unsigned SEQ_LEN     = 8;
    localparam int unsigned HEAD_DIM    = 4;  // one q or k row per word
    localparam int unsigned NUM_BLOCKS  = SEQ_LEN / TILE;
    localparam int unsigned ADDR_W      = 6;

    ////////////////////////////////////////
    // tile memory map (word addresses)
    ////////////////////////////////////////
    localparam logic [ADDR_W-1:0] Q_BASE    = 6'd0;  // q row r at Q_BASE + r
    localparam logic [ADDR_W-1:0] K_BASE    = 6'd8;  // k row r at K_BASE + r
    localparam logic [ADDR_W-1:0] S_BASE    = 6'd16; // score row r, block kb at +2r+kb
    localparam logic [ADDR_W-1:0] MAX_BASE  = 6'd32; // row max in low byte
    localparam logic [ADDR_W-1:0] CTRL_ADDR = 6'd63; // bit0 busy/start, bit1 done

    // 1/sqrt(HEAD_DIM) = 1/2
    localparam int unsigned SCALE_SHIFT = 1;

    ////////////////////////////////////////
    // sequencer states
    ////////////////////////////////////////
    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        FETCH     = 3'd1, // read q and k tiles of one block pair
        SCORE     = 3'd2, // write back four score rows
        WRITE_MAX = 3'd3, // dump the row maxima
        DONE      = 3'd4
    } seq_state_t;

endpackage

`default_nettype wire

// ==== logic/attn_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module attn_top (
    input  wire logic                               I_CLK,
    input  wire logic                               I_RST_N,
    input  wire logic                               psel_i,
    input  wire logic                               penable_i,
    input  wire logic                               pwrite_i,
    input  wire logic [attn_pkg::ADDR_W-1:0]        paddr_i,
    input  wire logic [attn_pkg::WORD_W-1:0]        pwdata_i,
    output logic                                    pready_o,
    output logic [attn_pkg::WORD_W-1:0]             prdata_o,
    output logic                                    done_o
);

    ////////////////////////////////////////
    // interconnect
    ////////////////////////////////////////
    logic                                   h_req, h_we, h_gnt, h_rvalid;
    logic [attn_pkg::ADDR_W-1:0]            h_addr;
    logic [attn_pkg::WORD_W-1:0]            h_wdata;
    logic                                   s_req, s_we, s_gnt, s_rvalid;
    logic [attn_pkg::ADDR_W-1:0]            s_addr;
    logic [attn_pkg::WORD_W-1:0]            s_wdata;
    logic [attn_pkg::WORD_W-1:0]            mem_rdata;   // shared read data
    logic                                   start, busy;
    logic                                   load_q, load_k, clear_max, upd_max;
    logic [$clog2(attn_pkg::TILE)-1:0]      load_row;
    logic [attn_pkg::WORD_W-1:0]            load_word;
    logic [$clog2(attn_pkg::SEQ_LEN)-1:0]   score_sel;   // global query row
    logic [attn_pkg::WORD_W-1:0]            score_row;
    logic [attn_pkg::ELEM_W-1:0]            row_max;

    apb_host_port i_apb_host_port (
        .I_CLK      (I_CLK),
        .I_RST_N    (I_RST_N),
        .psel_i     (psel_i),
        .penable_i  (penable_i),
        .pwrite_i   (pwrite_i),
        .paddr_i    (paddr_i),
        .pwdata_i   (pwdata_i),
        .done_i     (done_o),
        .busy_i     (busy),
        .h_gnt_i    (h_gnt),
        .h_rvalid_i (h_rvalid),
        .h_rdata_i  (mem_rdata),
        .pready_o   (pready_o),
        .prdata_o   (prdata_o),
        .start_o    (start),
        .h_req_o    (h_req),
        .h_we_o     (h_we),
        .h_addr_o   (h_addr),
        .h_wdata_o  (h_wdata)
    );

    tile_mem_arbiter i_tile_mem_arbiter (
        .I_CLK      (I_CLK),
        .I_RST_N    (I_RST_N),
        .h_req_i    (h_req),
        .h_we_i     (h_we),
        .h_addr_i   (h_addr),
        .h_wdata_i  (h_wdata),
        .s_req_i    (s_req),
        .s_we_i     (s_we),
        .s_addr_i   (s_addr),
        .s_wdata_i  (s_wdata),
        .h_gnt_o    (h_gnt),
        .s_gnt_o    (s_gnt),
        .h_rvalid_o (h_rvalid),
        .s_rvalid_o (s_rvalid),
        .rdata_o    (mem_rdata)
    );

    tile_sequencer i_tile_sequencer (
        .I_CLK       (I_CLK),
        .I_RST_N     (I_RST_N),
        .start_i     (start),
        .s_gnt_i     (s_gnt),
        .s_rvalid_i  (s_rvalid),
        .s_rdata_i   (mem_rdata),
        .score_row_i (score_row),
        .row_max_i   (row_max),
        .s_req_o     (s_req),
        .s_we_o      (s_we),
        .s_addr_o    (s_addr),
        .s_wdata_o   (s_wdata),
        .load_q_o    (load_q),
        .load_k_o    (load_k),
        .load_row_o  (load_row),
        .load_word_o (load_word),
        .clear_max_o (clear_max),
        .score_sel_o (score_sel),
        .upd_max_o   (upd_max),
        .busy_o      (busy),
        .done_o      (done_o)
    );

    score_engine i_score_engine (
        .I_CLK          (I_CLK),
        .I_RST_N        (I_RST_N),
        .load_q_i       (load_q),
        .load_k_i       (load_k),
        .load_row_i     (load_row),
        .load_word_i    (load_word),
        .clear_max_i    (clear_max),
        .score_sel_i    (score_sel[1:0]),        // row inside the q tile
        .upd_max_i      (upd_max),
        .max_base_row_i ({score_sel[2], 2'b00}), // first row of the query block
        .score_row_o    (score_row),
        .row_max_o      (row_max)
    );

endmodule

`default_nettype wire

// ==== logic/score_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module score_engine (
    input  wire logic                                   I_CLK,
    input  wire logic                                   I_RST_N,
    input  wire logic                                   load_q_i,
    input  wire logic                                   load_k_i,
    input  wire logic [$clog2(attn_pkg::TILE)-1:0]      load_row_i,
    input  wire logic [attn_pkg::WORD_W-1:0]            load_word_i,
    input  wire logic                                   clear_max_i,
    input  wire logic [$clog2(attn_pkg::TILE)-1:0]      score_sel_i,
    input  wire logic                                   upd_max_i,
    input  wire logic [$clog2(attn_pkg::SEQ_LEN)-1:0]   max_base_row_i,
    output logic [attn_pkg::WORD_W-1:0]                 score_row_o,
    output logic [attn_pkg::ELEM_W-1:0]                 row_max_o
);

    localparam int unsigned ACC_W   = 2 * attn_pkg::ELEM_W + 2; // four products summed
    localparam int unsigned MAX_IDX = $clog2(attn_pkg::SEQ_LEN);

    logic signed [attn_pkg::ELEM_W-1:0] q_tile  [attn_pkg::TILE][attn_pkg::HEAD_DIM];
    logic signed [attn_pkg::ELEM_W-1:0] k_tile  [attn_pkg::TILE][attn_pkg::HEAD_DIM];
    logic signed [attn_pkg::ELEM_W-1:0] max_reg [attn_pkg::SEQ_LEN];
    logic signed [ACC_W-1:0]            dot     [attn_pkg::TILE];
    logic signed [attn_pkg::ELEM_W-1:0] new_max;
    logic [MAX_IDX-1:0]                 max_idx;

    // scale by the shift, then clamp into int8
    function automatic logic [attn_pkg::ELEM_W-1:0] sat8(input logic signed [ACC_W-1:0] v);
        logic signed [ACC_W-1:0] s;
        s = v >>> attn_pkg::SCALE_SHIFT;
        if (s > ACC_W'(127)) begin
            return 8'h7f;
        end else if (s < -ACC_W'(128)) begin
            return 8'h80;
        end
        return s[attn_pkg::ELEM_W-1:0];
    endfunction

    ////////////////////////////////////////
    // tile registers
    ////////////////////////////////////////
    always_ff @(posedge I_CLK) begin
        for (int d = 0; d < attn_pkg::HEAD_DIM; d++) begin
            if (load_q_i) begin
                q_tile[load_row_i][d] <= load_word_i[d*attn_pkg::ELEM_W +: attn_pkg::ELEM_W];
            end
            if (load_k_i) begin
                k_tile[load_row_i][d] <= load_word_i[d*attn_pkg::ELEM_W +: attn_pkg::ELEM_W];
            end
        end
    end

    // q row against every k row, so k is used transposed
    always_comb begin
        logic signed [2*attn_pkg::ELEM_W-1:0] prod;
        for (int c = 0; c < attn_pkg::TILE; c++) begin
            dot[c] = '0;
            for (int d = 0; d < attn_pkg::HEAD_DIM; d++) begin
                prod   = q_tile[score_sel_i][d] * k_tile[c][d];
                dot[c] = dot[c] + ACC_W'(prod);
            end
            score_row_o[c*attn_pkg::ELEM_W +: attn_pkg::ELEM_W] = sat8(dot[c]);
        end
    end

    ////////////////////////////////////////
    // running row maxima
    ////////////////////////////////////////
    assign max_idx   = max_base_row_i + MAX_IDX'(score_sel_i);
    assign row_max_o = max_reg[max_idx];

    always_comb begin
        new_max = max_reg[max_idx];
        for (int c = 0; c < attn_pkg::TILE; c++) begin
            if ($signed(score_row_o[c*attn_pkg::ELEM_W +: attn_pkg::ELEM_W]) > new_max) begin
                new_max = score_row_o[c*attn_pkg::ELEM_W +: attn_pkg::ELEM_W];
            end
        end
    end

    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            for (int r = 0; r < attn_pkg::SEQ_LEN; r++) begin
                max_reg[r] <= 8'sh80; // most negative int8
            end
        end else if (clear_max_i) begin
            for (int r = 0; r < attn_pkg::SEQ_LEN; r++) begin
                max_reg[r] <= 8'sh80;
            end
        end else if (upd_max_i) begin
            max_reg[max_idx] <= new_max;
        end
    end

endmodule

`default_nettype wire

// ==== logic/tile_mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module tile_mem_arbiter (
    input  wire logic                           I_CLK,
    input  wire logic                           I_RST_N,
    input  wire logic                           h_req_i,
    input  wire logic                           h_we_i,
    input  wire logic [attn_pkg::ADDR_W-1:0]    h_addr_i,
    input  wire logic [attn_pkg::WORD_W-1:0]    h_wdata_i,
    input  wire logic                           s_req_i,
    input  wire logic                           s_we_i,
    input  wire logic [attn_pkg::ADDR_W-1:0]    s_addr_i,
    input  wire logic [attn_pkg::WORD_W-1:0]    s_wdata_i,
    output logic                                h_gnt_o,
    output logic                                s_gnt_o,
    output logic                                h_rvalid_o,
    output logic                                s_rvalid_o,
    output logic [attn_pkg::WORD_W-1:0]         rdata_o
);

    localparam int unsigned DEPTH = 2 ** attn_pkg::ADDR_W;

    logic [attn_pkg::WORD_W-1:0] mem [DEPTH];

    logic                           acc_valid;
    logic                           acc_we;
    logic [attn_pkg::ADDR_W-1:0]    acc_addr;
    logic [attn_pkg::WORD_W-1:0]    acc_wdata;

    ////////////////////////////////////////
    // fixed priority, sequencer first
    ////////////////////////////////////////
    assign s_gnt_o = s_req_i;
    assign h_gnt_o = h_req_i & ~s_req_i; // host waits behind sequencer

    always_comb begin
        acc_valid = s_req_i | h_req_i;
        if (s_req_i) begin
            acc_we    = s_we_i;
            acc_addr  = s_addr_i;
            acc_wdata = s_wdata_i;
        end else begin
            acc_we    = h_we_i;
            acc_addr  = h_addr_i;
            acc_wdata = h_wdata_i;
        end
    end

    // storage and read port
    always_ff @(posedge I_CLK) begin
        if (acc_valid && acc_we) begin
            mem[acc_addr] <= acc_wdata;
        end
        if (acc_valid && !acc_we) begin
            rdata_o <= mem[acc_addr];
        end
    end

    // which peer owns next cycle's read data
    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            h_rvalid_o <= 1'b0;
            s_rvalid_o <= 1'b0;
        end else begin
            h_rvalid_o <= h_gnt_o & ~h_we_i;
            s_rvalid_o <= s_gnt_o & ~s_we_i;
        end
    end

endmodule

`default_nettype wire

// ==== logic/tile_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tile_sequencer (
    input  wire logic                                   I_CLK,
    input  wire logic                                   I_RST_N,
    input  wire logic                                   start_i,
    input  wire logic                                   s_gnt_i,
    input  wire logic                                   s_rvalid_i,
    input  wire logic [attn_pkg::WORD_W-1:0]            s_rdata_i,
    input  wire logic [attn_pkg::WORD_W-1:0]            score_row_i,
    input  wire logic [attn_pkg::ELEM_W-1:0]            row_max_i,
    output logic                                        s_req_o,
    output logic                                        s_we_o,
    output logic [attn_pkg::ADDR_W-1:0]                 s_addr_o,
    output logic [attn_pkg::WORD_W-1:0]                 s_wdata_o,
    output logic                                        load_q_o,
    output logic                                        load_k_o,
    output logic [$clog2(attn_pkg::TILE)-1:0]           load_row_o,
    output logic [attn_pkg::WORD_W-1:0]                 load_word_o,
    output logic                                        clear_max_o,
    output logic [$clog2(attn_pkg::SEQ_LEN)-1:0]        score_sel_o,
    output logic                                        upd_max_o,
    output logic                                        busy_o,
    output logic                                        done_o
);

    localparam int unsigned FETCH_N = 2 * attn_pkg::TILE; // q rows then k rows

    attn_pkg::seq_state_t   state;
    logic                   kb;         // key block, outer loop
    logic                   qb;         // query block, inner loop
    logic [3:0]             issue_cnt;  // reads issued this pair
    logic [2:0]             recv_cnt;   // reads returned this pair
    logic [2:0]             wr_cnt;     // score rows or max words written
    logic                   done_r;

    ////////////////////////////////////////
    // block loop FSM
    ////////////////////////////////////////
    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            state     <= attn_pkg::IDLE;
            kb        <= 1'b0;
            qb        <= 1'b0;
            issue_cnt <= '0;
            recv_cnt  <= '0;
            wr_cnt    <= '0;
            done_r    <= 1'b0;
        end else begin
            case (state)
                attn_pkg::IDLE: begin
                    if (start_i) begin
                        state     <= attn_pkg::FETCH;
                        kb        <= 1'b0;
                        qb        <= 1'b0;
                        issue_cnt <= '0;
                        recv_cnt  <= '0;
                        done_r    <= 1'b0; // sticky done ends here
                    end
                end
                attn_pkg::FETCH: begin
                    if (s_req_o && s_gnt_i) begin
                        issue_cnt <= issue_cnt + 4'd1;
                    end
                    if (s_rvalid_i) begin
                        recv_cnt <= recv_cnt + 3'd1;
                        if (recv_cnt == 3'(FETCH_N - 1)) begin
                            state  <= attn_pkg::SCORE;
                            wr_cnt <= '0;
                        end
                    end
                end
                attn_pkg::SCORE: begin
                    if (s_gnt_i) begin
                        wr_cnt <= wr_cnt + 3'd1;
                        if (wr_cnt[1:0] == 2'(attn_pkg::TILE - 1)) begin
                            wr_cnt    <= '0;
                            issue_cnt <= '0;
                            recv_cnt  <= '0;
                            qb        <= ~qb;
                            if (!qb) begin
                                state <= attn_pkg::FETCH;
                            end else if (!kb) begin
                                kb    <= 1'b1;
                                state <= attn_pkg::FETCH;
                            end else begin
                                state <= attn_pkg::WRITE_MAX;
                            end
                        end
                    end
                end
                attn_pkg::WRITE_MAX: begin
                    if (s_gnt_i) begin
                        wr_cnt <= wr_cnt + 3'd1;
                        if (wr_cnt == 3'(attn_pkg::SEQ_LEN - 1)) begin
                            state <= attn_pkg::DONE;
                        end
                    end
                end
                attn_pkg::DONE: begin
                    done_r <= 1'b1;
                    state  <= attn_pkg::IDLE;
                end
                default: state <= attn_pkg::IDLE;
            endcase
        end
    end

    ////////////////////////////////////////
    // memory requests
    ////////////////////////////////////////
    always_comb begin
        s_req_o   = 1'b0;
        s_we_o    = 1'b0;
        s_addr_o  = '0;
        s_wdata_o = '0;
        case (state)
            attn_pkg::FETCH: begin
                s_req_o = (issue_cnt < 4'(FETCH_N));
                if (!issue_cnt[2]) begin
                    s_addr_o = attn_pkg::Q_BASE + {3'b000, qb, issue_cnt[1:0]};
                end else begin
                    s_addr_o = attn_pkg::K_BASE + {3'b000, kb, issue_cnt[1:0]};
                end
            end
            attn_pkg::SCORE: begin
                s_req_o   = 1'b1;
                s_we_o    = 1'b1;
                s_addr_o  = attn_pkg::S_BASE + {2'b00, qb, wr_cnt[1:0], kb}; // 2r + kb
                s_wdata_o = score_row_i;
            end
            attn_pkg::WRITE_MAX: begin
                s_req_o   = 1'b1;
                s_we_o    = 1'b1;
                s_addr_o  = attn_pkg::MAX_BASE + {3'b000, wr_cnt};
                s_wdata_o = {{(attn_pkg::WORD_W-attn_pkg::ELEM_W){1'b0}}, row_max_i};
            end
            default: ;
        endcase
    end

    // returning words go to the q tile first, then the k tile
    assign load_q_o    = s_rvalid_i & ~recv_cnt[2];
    assign load_k_o    = s_rvalid_i & recv_cnt[2];
    assign load_row_o  = recv_cnt[1:0];
    assign load_word_o = s_rdata_i;

    assign clear_max_o = (state == attn_pkg::IDLE) & start_i;
    assign upd_max_o   = (state == attn_pkg::SCORE) & s_gnt_i; // fold as the row is written
    assign score_sel_o = (state == attn_pkg::WRITE_MAX) ? wr_cnt : {qb, wr_cnt[1:0]};

    assign busy_o = (state != attn_pkg::IDLE);
    assign done_o = done_r;

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build with verilator, run, and judge the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module attn_tb -f src.f -o attn_sim \
    || { echo "build failed"; exit 1; }

./obj_dir/attn_sim > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log

grep -qx "TESTS PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== src.f ====
logic/attn_pkg.sv
logic/apb_host_port.sv
logic/tile_mem_arbiter.sv
logic/tile_sequencer.sv
logic/score_engine.sv
logic/attn_top.sv
tests/attn_tb.sv

// ==== tests/attn_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module attn_tb;

    localparam int unsigned XFER_CNT        = 61 + 36; // first run, then second run
    localparam int unsigned RUN_CNT         = 2;
    localparam int unsigned WATCHDOG_CYCLES = 200 * XFER_CNT + 2000 * RUN_CNT;

    logic                           I_CLK;
    logic                           I_RST_N;
    logic                           psel;
    logic                           penable;
    logic                           pwrite;
    logic [attn_pkg::ADDR_W-1:0]    paddr;
    logic [attn_pkg::WORD_W-1:0]    pwdata;
    logic                           pready;
    logic [attn_pkg::WORD_W-1:0]    prdata;
    logic                           done;

    logic [31:0]    tdata [40];     // q rows, k rows, scores, maxima
    logic [31:0]    q_rows [8];
    logic [31:0]    k_rows [8];
    logic [31:0]    exp_score [16]; // index 2r + kb
    logic [31:0]    exp_max [8];
    int             errors;
    int             checks;

    attn_top i_attn_top (
        .I_CLK     (I_CLK),
        .I_RST_N   (I_RST_N),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .pready_o  (pready),
        .prdata_o  (prdata),
        .done_o    (done)
    );

    initial begin
        I_CLK = 1'b0;
        forever #2 I_CLK = ~I_CLK;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge I_CLK);
        $display("watchdog: the run timed out after %0d cycles", WATCHDOG_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    ////////////////////////////////////////
    // checks and expected values
    ////////////////////////////////////////
    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, expected);
        end
    endtask

    // dot product, arithmetic shift by one, clamp to int8
    function automatic logic [7:0] scaled_score(input logic [31:0] q, input logic [31:0] k);
        int acc;
        int s;
        acc = 0;
        for (int d = 0; d < 4; d++) begin
            acc += int'($signed(q[d*8 +: 8])) * int'($signed(k[d*8 +: 8]));
        end
        s = acc >>> 1;
        if (s > 127) begin
            s = 127;
        end else if (s < -128) begin
            s = -128;
        end
        return s[7:0];
    endfunction

    function automatic logic [31:0] score_word(input int r, input int kb);
        logic [31:0] w;
        for (int c = 0; c < 4; c++) begin
            w[c*8 +: 8] = scaled_score(q_rows[r], k_rows[kb*4 + c]); // column c of key block
        end
        return w;
    endfunction

    function automatic logic [31:0] max_word(input int r);
        logic signed [7:0] m;
        logic signed [7:0] s;
        m = 8'sh80;
        for (int c = 0; c < 8; c++) begin
            s = scaled_score(q_rows[r], k_rows[c]);
            if (s > m) begin
                m = s;
            end
        end
        return {24'h0, m};
    endfunction

    ////////////////////////////////////////
    // APB driver
    ////////////////////////////////////////
    task automatic apb_transfer(input logic wr, input logic [5:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata);
        int unsigned gap;
        @(posedge I_CLK);
        psel    <= 1'b1;                // setup phase
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge I_CLK);
        penable <= 1'b1;
        @(negedge I_CLK);
        while (!pready) begin
            @(negedge I_CLK);           // host held off by the sequencer
        end
        rdata = prdata;
        @(posedge I_CLK);
        psel    <= 1'b0;
        penable <= 1'b0;
        gap = $urandom % 32'd4;
        repeat (gap) @(posedge I_CLK);
    endtask

    task automatic apb_write(input logic [5:0] addr, input logic [31:0] wdata);
        logic [31:0] unused_rd;
        apb_transfer(1'b1, addr, wdata, unused_rd);
    endtask

    task automatic apb_read(input logic [5:0] addr, output logic [31:0] rdata);
        apb_transfer(1'b0, addr, 32'h0, rdata);
    endtask

    task automatic wait_done();
        do begin
            @(negedge I_CLK);
        end while (done !== 1'b1);
    endtask

    task automatic check_results(input string tag);
        logic [31:0] rd;
        for (int i = 0; i < 16; i++) begin
            apb_read(attn_pkg::S_BASE + 6'(i), rd);
            compare_word($sformatf("%s score row %0d kb %0d", tag, i / 2, i % 2),
                         rd, exp_score[i]);
        end
        for (int r = 0; r < 8; r++) begin
            apb_read(attn_pkg::MAX_BASE + 6'(r), rd);
            compare_word($sformatf("%s max row %0d", tag, r), rd, exp_max[r]);
        end
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////
    initial begin
        logic [31:0]    rd;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        I_RST_N = 1'b0;
        errors  = 0;
        checks  = 0;
        void'($urandom(32'h836c_4031));
        $readmemh("tests/attn_testdata.txt", tdata);
        for (int i = 0; i < 8; i++) begin
            q_rows[i]  = tdata[i];
            k_rows[i]  = tdata[8 + i];
            exp_max[i] = tdata[32 + i];
        end
        for (int i = 0; i < 16; i++) begin
            exp_score[i] = tdata[16 + i];
        end
        repeat (5) @(posedge I_CLK);
        I_RST_N <= 1'b1;

        apb_read(attn_pkg::CTRL_ADDR, rd);
        compare_word("status after reset", rd, 32'h0);
        @(negedge I_CLK);
        compare_word("done_o after reset", {31'h0, done}, 32'h0);
        for (int i = 0; i < 8; i++) begin
            apb_write(attn_pkg::Q_BASE + 6'(i), q_rows[i]);
            apb_write(attn_pkg::K_BASE + 6'(i), k_rows[i]);
        end
        for (int i = 0; i < 8; i++) begin
            apb_read(attn_pkg::Q_BASE + 6'(i), rd);
            compare_word($sformatf("q row %0d", i), rd, q_rows[i]);
            apb_read(attn_pkg::K_BASE + 6'(i), rd);
            compare_word($sformatf("k row %0d", i), rd, k_rows[i]);
        end

        // first run against the data file
        apb_write(attn_pkg::CTRL_ADDR, 32'h1);
        apb_read(attn_pkg::CTRL_ADDR, rd);
        compare_word("status while busy", rd, 32'h1);
        @(negedge I_CLK);
        compare_word("done_o while busy", {31'h0, done}, 32'h0);
        apb_read(attn_pkg::Q_BASE + 6'd5, rd);       // competes with the sequencer
        compare_word("q row 5 during run", rd, q_rows[5]);
        wait_done();
        apb_read(attn_pkg::CTRL_ADDR, rd);
        compare_word("status after run 1", rd, 32'h2);
        check_results("run 1");

        // second run with negated keys
        for (int i = 0; i < 8; i++) begin
            for (int d = 0; d < 4; d++) begin
                k_rows[i][d*8 +: 8] = -k_rows[i][d*8 +: 8];
            end
            apb_write(attn_pkg::K_BASE + 6'(i), k_rows[i]);
        end
        for (int r = 0; r < 8; r++) begin
            exp_score[2*r]     = score_word(r, 0);
            exp_score[2*r + 1] = score_word(r, 1);
            exp_max[r]         = max_word(r);
        end
        apb_write(attn_pkg::CTRL_ADDR, 32'h1);
        apb_write(attn_pkg::CTRL_ADDR, 32'h1);      // lands while busy and is ignored
        apb_read(attn_pkg::CTRL_ADDR, rd);
        compare_word("status while busy", rd, 32'h1);
        @(negedge I_CLK);
        compare_word("done_o while busy", {31'h0, done}, 32'h0);
        wait_done();
        apb_read(attn_pkg::CTRL_ADDR, rd);
        compare_word("status after run 2", rd, 32'h2);
        check_results("run 2");

        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/attn_testdata.txt ====
// words 0-7 q rows, 8-15 k rows (signed bytes, lane 0 in bits 7..0)
// words 16-31 score words at 2r+kb, words 32-39 row maxima in the low byte
04030201 // q0
050200ff
0014f60a
00000000
00006464
0000329c
f907fd03
08f90605
00000001 // k0
00000100
02020202
ffffffff
0001fe03
04000000
02fd04fb
ff010101
fb0a0100 // score row 0 kb 0
01010801
fd0600ff
fe040aff
f614fb05
0ab50023
00000000
00000000
9c7f3232
64ce0032
19ce19ce
e77f0080
0000fe01
07e1f20b
fa0c0302
fe1210fe
0000000a // max row 0
0000000a
00000023
00000000
0000007f
0000007f
0000000b
00000012
